//--- Makefile
# Verilator build for the floating-point divider and its testbench

TOP = tbFpDiv

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module fpDivTop \
		fpFormatPkg.sv divCtrlPkg.sv divOperandUnpack.sv divMantIterate.sv \
		divRounder.sv fpDivTop.sv
	verilator --lint-only --timing --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f flist.f -o simFpDiv
	@out="$$(./obj_dir/simFpDiv)"; echo "$$out"; \
		echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

//--- divCtrlPkg.sv
// Divider control package
// sequencer states, the special-case classes found by the operand
// unpacker and the sizes of the mantissa iteration
package divCtrlPkg;

   typedef enum logic [1:0] {
      stIdle,
      stRun,
      stDone
   } seqState;

   // outcome of the operand classification, spNone is an ordinary divide
   typedef enum logic [2:0] {
      spNone,
      spNaN,
      spDivZero,
      spInf,
      spZero
   } specialClass;

   // 24 result bits plus guard plus one extra bit for the [0.5,1) case
   localparam int quotWidth = 26;
   localparam int expDiffWidth = 10;

endpackage

//--- divMantIterate.sv
// Restoring mantissa divider
// computes floor(dividend * 2^25 / divisor) one quotient bit per clock,
// 26 bits in all, and reports whether the final remainder is zero;
// the first bit is formed on the same edge that accepts iterStart
module divMantIterate (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                iterStart,
   input  logic [fpFormatPkg::fracWidth:0]     dividend,
   input  logic [fpFormatPkg::fracWidth:0]     divisor,
   output logic                                iterDone,
   output logic [divCtrlPkg::quotWidth-1:0]    quotient,
   output logic                                remZero
);
   import fpFormatPkg::*;
   import divCtrlPkg::*;

   localparam int mantWidth = fracWidth + 1;
   localparam int cntWidth = $clog2(quotWidth);

   logic                busy;
   logic [cntWidth-1:0] bitsLeft;
   logic                stepEn;
   // partial remainder stays below twice the divisor, so one spare bit
   logic [mantWidth:0]   partRem;
   logic [mantWidth:0]   remIn;
   logic [mantWidth+1:0] trialDiff;
   logic                 quotBit;
   logic [mantWidth-1:0] remKeep;

   // on the start edge the dividend itself is the first partial remainder
   assign remIn = busy ? partRem : {1'b0, dividend};
   assign stepEn = busy || iterStart;

   // trial subtraction, a clear sign bit means the divisor fits
   assign trialDiff = {1'b0, remIn} - {2'b00, divisor};
   assign quotBit = ~trialDiff[mantWidth+1];

   // whichever value is kept is below the divisor and fits mantWidth bits
   assign remKeep = quotBit ? trialDiff[mantWidth-1:0] : remIn[mantWidth-1:0];

   // the last step shifts a zero in, so this tests the true remainder
   assign remZero = (partRem == '0);

   always_ff @(posedge clk) begin
      if (rst) begin
         busy <= 1'b0;
         bitsLeft <= '0;
         iterDone <= 1'b0;
      end else begin
         iterDone <= 1'b0;
         if (!busy && iterStart) begin
            busy <= 1'b1;
            bitsLeft <= cntWidth'(quotWidth - 1);
         end else if (busy) begin
            bitsLeft <= bitsLeft - 1'b1;
            // the step taken with one bit left produces the final LSB
            if (bitsLeft == cntWidth'(1)) begin
               busy <= 1'b0;
               iterDone <= 1'b1;
            end
         end
      end
   end

   // quotient shifts in MSB first, 26 shifts flush any previous result
   always_ff @(posedge clk) begin
      if (stepEn) begin
         partRem <= {remKeep, 1'b0};
         quotient <= {quotient[quotWidth-2:0], quotBit};
      end
   end

endmodule

//--- divOperandUnpack.sv
// Operand unpacker for the floating-point divider
// splits both operands into fields, inserts the hidden bit, flushes
// denormals to zero and reports them, forms the biased exponent
// difference and sorts the operation into its special-case class
module divOperandUnpack (
   input  logic [31:0]                                 opA,
   input  logic [31:0]                                 opB,
   output logic [fpFormatPkg::fracWidth:0]             mantA,
   output logic [fpFormatPkg::fracWidth:0]             mantB,
   output logic signed [divCtrlPkg::expDiffWidth-1:0]  expDiff,
   output logic                                        signQ,
   output divCtrlPkg::specialClass                     spClass,
   output logic                                        denormIn
);
   import fpFormatPkg::*;
   import divCtrlPkg::*;

   logic [31:0]          opWord [2];
   logic [expWidth-1:0]  expField [2];
   logic [fracWidth-1:0] fracField [2];
   logic [fracWidth:0]   mantOp [2];
   logic [1:0]           isZero;
   logic [1:0]           isDenorm;
   logic [1:0]           isInf;
   logic [1:0]           isNaN;

   // index 0 is the dividend, index 1 the divisor
   assign opWord[0] = opA;
   assign opWord[1] = opB;

   for (genvar i = 0; i < 2; i++) begin : gOperand
      assign expField[i] = opWord[i][fracWidth +: expWidth];
      assign fracField[i] = opWord[i][fracWidth-1:0];
      // a zero exponent field covers both true zero and denormals
      assign isZero[i] = (expField[i] == '0);
      assign isDenorm[i] = isZero[i] && (fracField[i] != '0);
      assign isInf[i] = (expField[i] == '1) && (fracField[i] == '0);
      assign isNaN[i] = (expField[i] == '1) && (fracField[i] != '0);
      // denormals lose their fraction and divide as zero
      assign mantOp[i] = isZero[i] ? '0 : {1'b1, fracField[i]};
   end

   assign mantA = mantOp[0];
   assign mantB = mantOp[1];

   assign signQ = opA[expWidth+fracWidth] ^ opB[expWidth+fracWidth];
   assign denormIn = |isDenorm;

   // the bias is added back here so the rounder sees a biased exponent
   assign expDiff = expDiffWidth'(expField[0]) - expDiffWidth'(expField[1])
                  + expDiffWidth'(expBias);

   // first matching rule wins, so inf/0 lands in spInf and 0/inf in spZero
   always_comb begin
      if ((|isNaN) || (&isZero) || (&isInf)) begin
         spClass = spNaN;
      end else if (isInf[0]) begin
         spClass = spInf;
      end else if (isZero[1]) begin
         spClass = spDivZero;
      end else if (isZero[0] || isInf[1]) begin
         spClass = spZero;
      end else begin
         spClass = spNone;
      end
   end

endmodule

//--- divRounder.sv
// Quotient rounder for the single-precision divider
// normalizes the 26-bit quotient, rounds it by the requested mode with
// an exact sticky bit from the remainder, detects overflow and underflow
// and packs the result word, the five exception flags and denormIo;
// a special-case class overrides the arithmetic path entirely
module divRounder (
   input  logic [divCtrlPkg::quotWidth-1:0]            quotient,
   input  logic                                        remZero,
   input  logic signed [divCtrlPkg::expDiffWidth-1:0]  expDiff,
   input  logic                                        signQ,
   input  divCtrlPkg::specialClass                     spClass,
   input  logic                                        denormIn,
   input  fpFormatPkg::roundMode                       rm,
   output logic [31:0]                                 result,
   output logic [4:0]                                  flags,
   output logic                                        denormIo
);
   import fpFormatPkg::*;
   import divCtrlPkg::*;

   localparam int mantWidth = fracWidth + 1;
   localparam logic signed [expDiffWidth-1:0] expAllOnes = (1 << expWidth) - 1;

   logic                           normTop;
   logic [mantWidth-1:0]           mantNorm;
   logic                           guardBit;
   logic                           stickyBit;
   logic                           roundUp;
   logic [mantWidth:0]             mantRnd;
   logic signed [expDiffWidth-1:0] expNorm;
   logic signed [expDiffWidth-1:0] expFinal;
   logic                           arith;
   logic                           overflow;
   logic                           underflow;
   logic                           toZeroDir;
   logic                           inexact;

   // a quotient in [1,2) has its top bit set, otherwise it lies in [0.5,1)
   assign normTop = quotient[quotWidth-1];
   assign mantNorm = normTop ? quotient[quotWidth-1 -: mantWidth]
                             : quotient[quotWidth-2 -: mantWidth];
   assign guardBit = normTop ? quotient[1] : quotient[0];
   // the remainder is exact, so any nonzero remainder means bits below guard
   assign stickyBit = (normTop && quotient[0]) || !remZero;
   assign expNorm = expDiff - {{(expDiffWidth-1){1'b0}}, ~normTop};

   // the remainder is never negative, so only q or q+1 is ever chosen
   always_comb begin
      case (rm)
         rmNearestEven: roundUp = guardBit && (stickyBit || mantNorm[0]);
         rmTowardPos:   roundUp = !signQ && (guardBit || stickyBit);
         rmTowardNeg:   roundUp = signQ && (guardBit || stickyBit);
         default:       roundUp = 1'b0;
      endcase
   end

   assign mantRnd = {1'b0, mantNorm} + {{mantWidth{1'b0}}, roundUp};
   // a carry out leaves the fraction field all zero and bumps the exponent
   assign expFinal = expNorm + {{(expDiffWidth-1){1'b0}}, mantRnd[mantWidth]};

   assign arith = (spClass == spNone);
   assign overflow = arith && (expFinal >= expAllOnes);
   assign underflow = arith && (expFinal[expDiffWidth-1] || (expFinal == '0));
   assign inexact = guardBit || stickyBit || overflow || underflow;

   // modes whose rounding moves this sign toward zero saturate at the largest finite
   assign toZeroDir = (rm == rmTowardZero)
                   || ((rm == rmTowardPos) && signQ)
                   || ((rm == rmTowardNeg) && !signQ);

   assign denormIo = denormIn || underflow;

   always_comb begin
      result = {signQ, expFinal[expWidth-1:0], mantRnd[fracWidth-1:0]};
      flags = '0;
      case (spClass)
         spNaN: begin
            result = quietNaN;
            flags[flagInvalid] = 1'b1;
         end
         spDivZero: begin
            result = {signQ, {expWidth{1'b1}}, {fracWidth{1'b0}}};
            flags[flagDivZero] = 1'b1;
         end
         spInf: begin
            result = {signQ, {expWidth{1'b1}}, {fracWidth{1'b0}}};
         end
         spZero: begin
            result = {signQ, {(expWidth+fracWidth){1'b0}}};
         end
         default: begin
            // ordinary division
            flags[flagInexact] = inexact;
            if (overflow) begin
               flags[flagOverflow] = 1'b1;
               if (toZeroDir) begin
                  result = {signQ, {(expWidth-1){1'b1}}, 1'b0, {fracWidth{1'b1}}};
               end else begin
                  result = {signQ, {expWidth{1'b1}}, {fracWidth{1'b0}}};
               end
            end else if (underflow) begin
               // no gradual underflow, tiny results flush to signed zero
               flags[flagUnderflow] = 1'b1;
               result = {signQ, {(expWidth+fracWidth){1'b0}}};
            end
         end
      endcase
   end

endmodule

//--- flist.f
fpFormatPkg.sv
divCtrlPkg.sv
divOperandUnpack.sv
divMantIterate.sv
divRounder.sv
fpDivTop.sv
tbFpDiv.sv

//--- fpDivTop.sv
// Single-precision floating-point divider, top level
// a four-phase req/ack sequencer captures the operands and the rounding
// mode, runs the 26-cycle mantissa iteration and loads the rounded
// result; ack rises 28 clocks after the capturing edge for every case
module fpDivTop (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   req,
   input  logic [31:0]            a,
   input  logic [31:0]            b,
   input  fpFormatPkg::roundMode  rm,
   output logic                   ack,
   output logic [31:0]            result,
   output logic [4:0]             flags,
   output logic                   denormIo
);
   import fpFormatPkg::*;
   import divCtrlPkg::*;

   seqState state;
   logic [31:0] opA;
   logic [31:0] opB;
   roundMode    rmReg;
   logic        iterStart;
   logic        iterDone;
   logic [fracWidth:0]             mantA;
   logic [fracWidth:0]             mantB;
   logic signed [expDiffWidth-1:0] expDiff;
   logic                           signQ;
   specialClass                    spClass;
   logic                           denormIn;
   logic [quotWidth-1:0]           quotient;
   logic                           remZero;
   logic [31:0]                    resNext;
   logic [4:0]                     flagsNext;
   logic                           denormNext;

   // special cases run the full iteration too, which keeps latency fixed
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= stIdle;
         ack <= 1'b0;
         iterStart <= 1'b0;
      end else begin
         iterStart <= 1'b0;
         case (state)
            stIdle: begin
               if (req) begin
                  state <= stRun;
                  iterStart <= 1'b1;
               end
            end
            stRun: begin
               if (iterDone) state <= stDone;
            end
            stDone: begin
               // results were loaded on the edge that entered stDone
               if (ack && !req) begin
                  ack <= 1'b0;
                  state <= stIdle;
               end else begin
                  ack <= 1'b1;
               end
            end
            default: state <= stIdle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if ((state == stIdle) && req) begin
         opA <= a;
         opB <= b;
         rmReg <= rm;
      end
   end

   // outputs only change here, so they hold steady for the whole ack phase
   always_ff @(posedge clk) begin
      if ((state == stRun) && iterDone) begin
         result <= resNext;
         flags <= flagsNext;
         denormIo <= denormNext;
      end
   end

   divOperandUnpack unpack_inst (
      .opA      (opA),
      .opB      (opB),
      .mantA    (mantA),
      .mantB    (mantB),
      .expDiff  (expDiff),
      .signQ    (signQ),
      .spClass  (spClass),
      .denormIn (denormIn)
   );

   divMantIterate iterate_inst (
      .clk       (clk),
      .rst       (rst),
      .iterStart (iterStart),
      .dividend  (mantA),
      .divisor   (mantB),
      .iterDone  (iterDone),
      .quotient  (quotient),
      .remZero   (remZero)
   );

   divRounder rounder_inst (
      .quotient (quotient),
      .remZero  (remZero),
      .expDiff  (expDiff),
      .signQ    (signQ),
      .spClass  (spClass),
      .denormIn (denormIn),
      .rm       (rmReg),
      .result   (resNext),
      .flags    (flagsNext),
      .denormIo (denormNext)
   );

endmodule

//--- fpFormatPkg.sv
// Single-precision format package
// describes the IEEE-754 binary32 fields, the rounding-mode encoding,
// where each exception flag sits in the flags word and the quiet NaN
// that every invalid operation returns
package fpFormatPkg;

   // field widths of the 32-bit format, the sign takes the remaining bit
   localparam int expWidth = 8;
   localparam int fracWidth = 23;
   localparam int expBias = 127;

   // same two-bit encoding the requester already drives
   typedef enum logic [1:0] {
      rmNearestEven = 2'b00,
      rmTowardZero  = 2'b01,
      rmTowardPos   = 2'b10,
      rmTowardNeg   = 2'b11
   } roundMode;

   // bit positions inside the 5-bit flags word, inexact is the top bit
   localparam int flagInexact = 4;
   localparam int flagUnderflow = 3;
   localparam int flagOverflow = 2;
   localparam int flagDivZero = 1;
   localparam int flagInvalid = 0;

   // positive quiet NaN with only the top fraction bit set
   localparam logic [31:0] quietNaN = 32'h7fc0_0000;

endpackage

//--- tbFpDiv.sv
// Testbench for the single-precision floating-point divider
// drives four-phase req/ack transactions into fpDivTop, predicts every
// answer with an integer long-division model of the format rules and
// compares result, flags and denormIo whenever ack rises
module tbFpDiv;
   timeunit 1ns;
   timeprecision 100ps;

   import fpFormatPkg::*;

   logic        clk = 1'b0;
   logic        rst;
   logic        req;
   logic [31:0] a;
   logic [31:0] b;
   roundMode    rm;
   logic        ack;
   logic [31:0] result;
   logic [4:0]  flags;
   logic        denormIo;

   logic [31:0] expResult;
   logic [4:0]  expFlags;
   logic        expDenorm;
   logic [31:0] rngState = 32'hf85dd8a2;
   logic        timedOut = 1'b0;
   int          errorCount = 0;
   int          checkCount = 0;

   // an exact halfway quotient cannot come out of 24-bit operands,
   // so these pairs sit just beside it or divide exactly
   logic [31:0] dirA [8] = '{32'h40c00000, 32'h3f800000, 32'h41200000, 32'h3f800000,
                             32'h40000000, 32'h3f800001, 32'h3f7fffff, 32'h4b7fffff};
   logic [31:0] dirB [8] = '{32'h40400000, 32'h3f800000, 32'h40a00000, 32'h40400000,
                             32'h40400000, 32'h3fc00000, 32'h3f800001, 32'h4b7ffffe};

   always #20 clk = ~clk;

   fpDivTop fpDivTop_inst (
      .clk      (clk),
      .rst      (rst),
      .req      (req),
      .a        (a),
      .b        (b),
      .rm       (rm),
      .ack      (ack),
      .result   (result),
      .flags    (flags),
      .denormIo (denormIo)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // random sign and fraction with a biased exponent between 96 and 159
   function automatic logic [31:0] normalOperand(input logic [31:0] r);
      return {r[31], 8'd96 + {2'b00, r[5:0]}, r[30:8]};
   endfunction

   // expected {result, flags, denormIo} for x / y under the given mode
   function automatic logic [37:0] refDiv(input logic [31:0] x, input logic [31:0] y,
                                          input logic [1:0] mode);
      logic [22:0] fx;
      logic [22:0] fy;
      int          ex;
      int          ey;
      int          e;
      logic        sq;
      logic        zx;
      logic        zy;
      logic        ix;
      logic        iy;
      logic        nx;
      logic        ny;
      logic        dn;
      logic        g;
      logic        s;
      logic        up;
      logic        satMax;
      longint      num;
      longint      den;
      longint      q;
      longint      r;
      longint      mant;
      logic [31:0] res;
      logic [4:0]  fl;
      fx = x[22:0];
      fy = y[22:0];
      ex = int'(x[30:23]);
      ey = int'(y[30:23]);
      sq = x[31] ^ y[31];
      zx = (ex == 0);
      zy = (ey == 0);
      ix = (ex == 255) && (fx == '0);
      iy = (ey == 255) && (fy == '0);
      nx = (ex == 255) && (fx != '0);
      ny = (ey == 255) && (fy != '0);
      dn = (zx && (fx != '0)) || (zy && (fy != '0));
      res = '0;
      fl = '0;
      if (nx || ny || (zx && zy) || (ix && iy)) begin
         res = 32'h7fc00000;
         fl = 5'b00001;
      end else if (ix) begin
         res = {sq, 31'h7f800000};
      end else if (zy) begin
         res = {sq, 31'h7f800000};
         fl = 5'b00010;
      end else if (zx || iy) begin
         res = {sq, 31'h0};
      end else begin
         // exact quotient of the two 24-bit mantissas scaled by 2^25
         num = longint'({1'b1, fx}) << 25;
         den = longint'({1'b1, fy});
         q = num / den;
         r = num % den;
         e = ex - ey + 127;
         if (q >= 64'sd33554432) begin
            mant = q >> 2;
            g = q[1];
            s = q[0] || (r != 0);
         end else begin
            mant = q >> 1;
            g = q[0];
            s = (r != 0);
            e = e - 1;
         end
         case (mode)
            2'b00: up = g && (s || mant[0]);
            2'b10: up = !sq && (g || s);
            2'b11: up = sq && (g || s);
            default: up = 1'b0;
         endcase
         if (up) mant = mant + 64'sd1;
         if (mant == 64'sd16777216) e = e + 1;
         if (e >= 255) begin
            satMax = (mode == 2'b01) || ((mode == 2'b10) && sq) || ((mode == 2'b11) && !sq);
            res = satMax ? {sq, 31'h7f7fffff} : {sq, 31'h7f800000};
            fl = 5'b10100;
         end else if (e <= 0) begin
            res = {sq, 31'h0};
            fl = 5'b11000;
         end else begin
            res = {sq, e[7:0], mant[22:0]};
            fl = {g || s, 4'b0000};
         end
      end
      dn = dn || fl[3];
      return {res, fl, dn};
   endfunction

   // compares the outputs once per transaction since they were loaded a clock before ack
   always @(posedge ack) begin
      checkCount++;
      if (result !== expResult) begin
         $display("CHECK FAILED time=%0t result expected=%h actual=%h",
                  $time, expResult, result);
         errorCount++;
      end
      if (flags !== expFlags) begin
         $display("CHECK FAILED time=%0t flags expected=%b actual=%b", $time, expFlags, flags);
         errorCount++;
      end
      if (denormIo !== expDenorm) begin
         $display("CHECK FAILED time=%0t denormIo expected=%b actual=%b",
                  $time, expDenorm, denormIo);
         errorCount++;
      end
   end

   // one four-phase request with req held holdCycles clocks past ack
   task automatic runTransaction(input logic [31:0] x, input logic [31:0] y,
                                 input logic [1:0] mode, input logic [31:0] wantRes,
                                 input logic [4:0] wantFlags, input logic wantDenorm,
                                 input int holdCycles);
      int cycles;
      if (timedOut) return;
      expResult = wantRes;
      expFlags = wantFlags;
      expDenorm = wantDenorm;
      @(posedge clk);
      #2;
      a = x;
      b = y;
      rm = roundMode'(mode);
      req = 1'b1;
      // the first edge counted is the capturing one
      cycles = 0;
      do begin
         @(posedge clk);
         #1;
         cycles++;
      end while (!ack && (cycles <= 100));
      if (!ack) begin
         $display("timeout: ack never rose for %h / %h", x, y);
         errorCount++;
         timedOut = 1'b1;
         req = 1'b0;
         return;
      end
      checkCount++;
      if (cycles - 1 != 28) begin
         $display("CHECK FAILED time=%0t ack latency expected=28 actual=%0d", $time, cycles - 1);
         errorCount++;
      end
      // while req stays high the answer must stay the predicted one
      repeat (holdCycles) begin
         @(posedge clk);
         #1;
         if (ack !== 1'b1) begin
            $display("CHECK FAILED time=%0t ack expected=1 actual=%b", $time, ack);
            errorCount++;
         end
         if (result !== expResult) begin
            $display("CHECK FAILED time=%0t result expected=%h actual=%h",
                     $time, expResult, result);
            errorCount++;
         end
      end
      #1;
      req = 1'b0;
      cycles = 0;
      do begin
         @(posedge clk);
         #1;
         cycles++;
      end while (ack && (cycles <= 100));
      if (ack) begin
         $display("timeout: ack never fell after req dropped for %h / %h", x, y);
         errorCount++;
         timedOut = 1'b1;
         return;
      end
      if (cycles != 1) begin
         $display("CHECK FAILED time=%0t ack fall cycles expected=1 actual=%0d", $time, cycles);
         errorCount++;
      end
   endtask

   task automatic checkAgainstRef(input logic [31:0] x, input logic [31:0] y,
                                  input logic [1:0] mode, input int holdCycles);
      logic [37:0] want;
      want = refDiv(x, y, mode);
      runTransaction(x, y, mode, want[37:6], want[5:1], want[0], holdCycles);
   endtask

   initial begin
      logic [31:0] opX;
      logic [31:0] opY;
      logic        sgn;
      logic        satMax;
      rst = 1'b1;
      req = 1'b0;
      a = '0;
      b = '0;
      rm = rmNearestEven;
      repeat (5) @(posedge clk);
      #2;
      rst = 1'b0;
      checkCount++;
      if (ack !== 1'b0) begin
         $display("CHECK FAILED time=%0t ack expected=0 actual=%b", $time, ack);
         errorCount++;
      end

      // exact quotients carry no flag at all
      runTransaction(32'h40c00000, 32'h40400000, 2'b00, 32'h40000000, 5'b0, 1'b0, 0);
      runTransaction(32'h41200000, 32'h40a00000, 2'b01, 32'h40000000, 5'b0, 1'b0, 2);
      runTransaction(32'h3f800000, 32'h40800000, 2'b11, 32'h3e800000, 5'b0, 1'b0, 1);

      for (int m = 0; m < 4; m++) begin
         for (int i = 0; i < 8; i++) begin
            checkAgainstRef(dirA[i], dirB[i], 2'(m), i % 3);
         end
      end

      for (int m = 0; m < 4; m++) begin
         for (int i = 0; i < 12; i++) begin
            rngState = xorshift(rngState);
            opX = normalOperand(rngState);
            rngState = xorshift(rngState);
            opY = normalOperand(rngState);
            checkAgainstRef(opX, opY, 2'(m), i % 3);
         end
      end

      // 2^127 / 0.25 overflows in every mode and for either sign
      for (int m = 0; m < 4; m++) begin
         for (int s = 0; s < 2; s++) begin
            sgn = 1'(s);
            satMax = (m == 1) || ((m == 2) && sgn) || ((m == 3) && !sgn);
            opX = satMax ? {sgn, 31'h7f7fffff} : {sgn, 31'h7f800000};
            runTransaction({sgn, 31'h7f000000}, 32'h3e800000, 2'(m), opX, 5'b10100, 1'b0, 1);
         end
      end

      // tiny quotients flush to signed zero and denormal operands divide as zero
      for (int m = 0; m < 4; m++) begin
         runTransaction(32'h00800000, 32'h40800000, 2'(m), 32'h00000000, 5'b11000, 1'b1, 0);
         runTransaction(32'h80800000, 32'h40000000, 2'(m), 32'h80000000, 5'b11000, 1'b1, 0);
      end
      runTransaction(32'h00000001, 32'h3f800000, 2'b00, 32'h00000000, 5'b00000, 1'b1, 0);
      runTransaction(32'h80400000, 32'h3f800000, 2'b00, 32'h80000000, 5'b00000, 1'b1, 1);
      runTransaction(32'h3f800000, 32'h00000001, 2'b00, 32'h7f800000, 5'b00010, 1'b1, 0);
      runTransaction(32'h00000001, 32'h00000000, 2'b00, 32'h7fc00000, 5'b00001, 1'b1, 0);

      // special operands
      runTransaction(32'h7fc00001, 32'h3f800000, 2'b00, 32'h7fc00000, 5'b00001, 1'b0, 0);
      runTransaction(32'h3f800000, 32'hffa00000, 2'b01, 32'h7fc00000, 5'b00001, 1'b0, 0);
      runTransaction(32'h00000000, 32'h80000000, 2'b00, 32'h7fc00000, 5'b00001, 1'b0, 0);
      runTransaction(32'h7f800000, 32'hff800000, 2'b10, 32'h7fc00000, 5'b00001, 1'b0, 0);
      runTransaction(32'h3f800000, 32'h80000000, 2'b00, 32'hff800000, 5'b00010, 1'b0, 0);
      runTransaction(32'hff800000, 32'h40000000, 2'b11, 32'hff800000, 5'b00000, 1'b0, 0);
      runTransaction(32'h7f800000, 32'h00000000, 2'b00, 32'h7f800000, 5'b00000, 1'b0, 0);
      runTransaction(32'h80000000, 32'h40000000, 2'b00, 32'h80000000, 5'b00000, 1'b0, 2);
      runTransaction(32'h40000000, 32'hff800000, 2'b10, 32'h80000000, 5'b00000, 1'b0, 0);

      $display("checks %0d, errors %0d", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule
